/* common/alu_cfg.svh */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Width of the operands and of the result word
`define ALU_DATA_WIDTH 8

// Opcode field, eight operations
`define ALU_OP_WIDTH 3

// Barrel mux layers, shifting by 1, 2 and 4
`define ALU_SHIFT_STAGES 3

`endif

/* common/alu_pkg.sv */
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_DATA_WIDTH-1:0] alu_word_t;

    // Opcode encoding as seen on the select field
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        op_mov  = 3'd0,
        op_add  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_mult = 3'd4,
        op_sll  = 3'd5,
        op_sra  = 3'd6,
        op_rot  = 3'd7
    } alu_op_e;

    // Fill behaviour of the shifter
    typedef enum logic [1:0] {
        shift_logical = 2'd0,
        shift_arith   = 2'd1,
        shift_rotate  = 2'd2
    } shift_kind_e;

    typedef struct packed {
        alu_op_e   op;
        alu_word_t data1;
        alu_word_t data2;
    } alu_req_t;

    typedef struct packed {
        alu_word_t result;
        logic      zero;
    } alu_rsp_t;

    // Second operand as a signed shift count
    typedef union packed {
        alu_word_t raw;
        struct packed {
            logic                        negative;
            logic [`ALU_DATA_WIDTH-2:0]  low;
        } fields;
    } shift_operand_u;

endpackage

`default_nettype wire

/* multiplier/array_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module array_multiplier
    import alu_pkg::*;
(
    input  alu_word_t data1,
    input  alu_word_t data2,
    output alu_word_t product
);

    localparam int W = `ALU_DATA_WIDTH;

    // Partial sum after each row, and the ripple carries inside a row
    wire [W-1:0] psum  [0:W-1];
    wire [W-1:0] carry [1:W-1];

    // Row 0 is data1 gated by the lowest multiplier bit
    assign psum[0] = data1 & {W{data2[0]}};

    generate
        for (genvar r = 1; r < W; r++) begin : g_row
            for (genvar b = 0; b < W; b++) begin : g_bit
                if (b < r) begin : g_pass
                    // Bits already settled by earlier rows
                    assign psum[r][b]  = psum[r-1][b];
                    assign carry[r][b] = 1'b0;
                end else begin : g_fa
                    wire a;
                    wire p;
                    wire cin;

                    assign a   = psum[r-1][b];
                    assign p   = data2[r] & data1[b-r];
                    assign cin = carry[r][b];

                    // Full adder sum
                    assign psum[r][b] = a ^ p ^ cin;

                    // Carry into the next column unless this is the top bit
                    if (b < W - 1) begin : g_carry
                        assign carry[r][b+1] = (a & p) | (cin & (a ^ p));
                    end
                    // First active column of a row has no carry in
                    if (b == r) begin : g_cin0
                        assign carry[r][b] = 1'b0;
                    end
                end
            end
        end
    endgenerate

    // Low word of the product only
    assign product = psum[W-1];

endmodule

`default_nettype wire

/* shifter/barrel_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module barrel_shifter
    import alu_pkg::*;
(
    input  alu_word_t                    data,
    input  logic [`ALU_SHIFT_STAGES-1:0] stages,
    input  shift_kind_e                  kind,
    output alu_word_t                    result
);

    localparam int W = `ALU_DATA_WIDTH;
    localparam int S = `ALU_SHIFT_STAGES;

    // Word entering each mux layer, last entry is the output
    wire [W-1:0] layer [0:S];

    assign layer[0] = data;

    generate
        for (genvar s = 0; s < S; s++) begin : g_stage
            localparam int SH = 1 << s;

            for (genvar b = 0; b < W; b++) begin : g_bit
                if (b + SH < W) begin : g_inner
                    assign layer[s+1][b] = stages[s] ? layer[s][b+SH] : layer[s][b];
                end else begin : g_edge
                    wire fill;

                    // Vacated top bits, chosen by the shift kind
                    assign fill = (kind == shift_rotate) ? layer[s][b+SH-W] :
                                  (kind == shift_arith)  ? layer[s][W-1]    : 1'b0;

                    assign layer[s+1][b] = stages[s] ? fill : layer[s][b];
                end
            end
        end
    endgenerate

    assign result = layer[S];

endmodule

`default_nettype wire

/* shifter/shift_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module shift_unit
    import alu_pkg::*;
(
    input  alu_word_t   data,
    input  alu_word_t   amount,
    input  shift_kind_e kind,
    output alu_word_t   result
);

    localparam int W = `ALU_DATA_WIDTH;
    localparam int S = `ALU_SHIFT_STAGES;

    shift_operand_u amount_view;
    logic           shift_left;
    alu_word_t      magnitude;
    logic           saturate;
    alu_word_t      barrel_in;
    alu_word_t      barrel_out;
    alu_word_t      shifted;
    shift_kind_e    barrel_kind;

    // Mirror a word so a right shift acts as a left shift
    function automatic alu_word_t reverse_word(input alu_word_t w);
        alu_word_t r;
        for (int i = 0; i < W; i++) begin
            r[i] = w[W-1-i];
        end
        return r;
    endfunction

    assign amount_view = amount;

    // Sign bit gives direction, two's complement gives the count
    assign shift_left = ~amount_view.fields.negative;
    assign magnitude  = shift_left ? amount_view.raw : alu_word_t'(-amount_view.raw);

    // Any count of 8 or more, including 8'h80
    assign saturate = |magnitude[W-1:S];

    assign barrel_in = shift_left ? reverse_word(data) : data;

    // No sign fill when shifting left
    always_comb begin
        if (shift_left && kind == shift_arith) begin
            barrel_kind = shift_logical;
        end else begin
            barrel_kind = kind;
        end
    end

    barrel_shifter u_barrel (
        .data   (barrel_in),
        .stages (magnitude[S-1:0]),
        .kind   (barrel_kind),
        .result (barrel_out)
    );

    assign shifted = shift_left ? reverse_word(barrel_out) : barrel_out;

    // Saturation and the sign hold; rotate wraps modulo 8 by itself
    always_comb begin
        result = shifted;
        case (kind)
            shift_logical: begin
                if (saturate) begin
                    result = '0;
                end
            end
            shift_arith: begin
                if (shift_left) begin
                    result[W-1] = data[W-1];
                    if (saturate) begin
                        result[W-2:0] = '0;
                    end
                end else if (saturate) begin
                    result = {W{data[W-1]}};
                end
            end
            default: begin
                result = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_cfg.svh"

module alu
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  alu_req_t req,
    output alu_rsp_t rsp
);

    alu_word_t   add_result;
    alu_word_t   and_result;
    alu_word_t   or_result;
    alu_word_t   mult_result;
    alu_word_t   shift_result;
    alu_word_t   next_result;
    shift_kind_e kind;
    logic        next_zero;

    // Simple operations, computed in place
    assign add_result = req.data1 + req.data2;
    assign and_result = req.data1 & req.data2;
    assign or_result  = req.data1 | req.data2;

    // Zero flag always follows the adder, for branch-if-equal
    assign next_zero = (add_result == '0);

    array_multiplier u_mult (
        .data1   (req.data1),
        .data2   (req.data2),
        .product (mult_result)
    );

    // Opcodes 5 to 7 pick the shifter fill mode
    always_comb begin
        case (req.op)
            op_sll:  kind = shift_logical;
            op_sra:  kind = shift_arith;
            default: kind = shift_rotate;
        endcase
    end

    shift_unit u_shift (
        .data   (req.data1),
        .amount (req.data2),
        .kind   (kind),
        .result (shift_result)
    );

    // Result select by opcode
    always_comb begin
        case (req.op)
            op_mov:  next_result = req.data2;
            op_add:  next_result = add_result;
            op_and:  next_result = and_result;
            op_or:   next_result = or_result;
            op_mult: next_result = mult_result;
            default: next_result = shift_result;
        endcase
    end

    // Output register, one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.result <= '0;
            rsp.zero   <= 1'b0;
        end else begin
            rsp.result <= next_result;
            rsp.zero   <= next_zero;
        end
    end

endmodule

`default_nettype wire

/* testbench/alu_tb_model.svh */
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

// Logical or arithmetic shift, amount is a signed count, negative means right
function automatic alu_word_t shifted_value(input logic arith, input alu_word_t data,
                                            input alu_word_t amount);
    int        count;
    int        mag;
    alu_word_t tmp;
    alu_word_t res;
    count = $signed(amount);
    mag   = (count < 0) ? -count : count;
    if (!arith) begin
        if (mag >= 8) begin
            res = 8'h00;
        end else if (count >= 0) begin
            res = data << mag;
        end else begin
            res = data >> mag;
        end
    end else if (count >= 0) begin
        // Bit 7 is held, the low seven bits move up
        if (mag >= 8) begin
            res = {data[7], 7'b0};
        end else begin
            tmp = data << mag;
            res = {data[7], tmp[6:0]};
        end
    end else begin
        if (mag >= 8) begin
            res = {8{data[7]}};
        end else begin
            res = $signed(data) >>> mag;
        end
    end
    return res;
endfunction

// Rotate by the magnitude modulo 8
function automatic alu_word_t rotated_value(input alu_word_t data, input alu_word_t amount);
    int          count;
    int          steps;
    logic [15:0] doubled;
    count   = $signed(amount);
    steps   = ((count < 0) ? -count : count) % 8;
    doubled = {data, data};
    if (count >= 0) begin
        doubled = doubled << steps;
        return doubled[15:8];
    end else begin
        doubled = doubled >> steps;
        return doubled[7:0];
    end
endfunction

function automatic alu_word_t expected_result(input alu_req_t r);
    int product;
    case (r.op)
        op_mov:  return r.data2;
        op_add:  return r.data1 + r.data2;
        op_and:  return r.data1 & r.data2;
        op_or:   return r.data1 | r.data2;
        op_mult: begin
            product = int'(r.data1) * int'(r.data2);
            return product[7:0];
        end
        op_sll:  return shifted_value(1'b0, r.data1, r.data2);
        op_sra:  return shifted_value(1'b1, r.data1, r.data2);
        default: return rotated_value(r.data1, r.data2);
    endcase
endfunction

// Flag follows the 8-bit sum for every opcode
function automatic logic zero_from_add(input alu_req_t r);
    alu_word_t sum;
    sum = r.data1 + r.data2;
    return (sum == 8'h00);
endfunction

`endif

/* testbench/alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_tb
    import alu_pkg::*;
();

    localparam int DRAIN_TIMEOUT = 20;

    logic      clk = 1'b0;
    logic      reset;
    alu_req_t  req;
    alu_rsp_t  rsp;

    // Request bookkeeping, one cycle behind the DUT input
    alu_req_t  prev_req;
    logic      prev_reset;
    logic      started = 1'b0;
    int        seq;
    int        prev_seq = 0;
    int        checked_seq = 0;
    alu_word_t exp_result;
    logic      exp_zero;

    integer    seed = 32'h4e967945;
    int        i;
    int        j;
    int        cycles;
    alu_word_t a;
    alu_word_t b;

    `include "alu_tb_model.svh"

    alu u_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        started    <= 1'b1;
        prev_req   <= req;
        prev_reset <= reset;
        prev_seq   <= seq;
        if (started) begin
            checked_seq <= prev_seq;
        end
    end

    // Reset clears both fields, otherwise the model of last cycle's request
    always_comb begin
        if (prev_reset) begin
            exp_result = 8'h00;
            exp_zero   = 1'b0;
        end else begin
            exp_result = expected_result(prev_req);
            exp_zero   = zero_from_add(prev_req);
        end
    end

    result_check: assert property (@(posedge clk) started |-> (rsp.result === exp_result))
        else begin
            $display("** Error: rsp.result is %h, expected %h (op %h, data1 %h, data2 %h)",
                     $sampled(rsp.result), $sampled(exp_result), $sampled(prev_req.op),
                     $sampled(prev_req.data1), $sampled(prev_req.data2));
            $display("TESTS FAILED");
            $fatal(1, "result mismatch");
        end

    zero_check: assert property (@(posedge clk) started |-> (rsp.zero === exp_zero))
        else begin
            $display("** Error: rsp.zero is %h, expected %h (data1 %h, data2 %h)",
                     $sampled(rsp.zero), $sampled(exp_zero),
                     $sampled(prev_req.data1), $sampled(prev_req.data2));
            $display("TESTS FAILED");
            $fatal(1, "zero flag mismatch");
        end

    // One request per cycle, driven just after the edge
    task automatic drive_request(input alu_op_e op, input alu_word_t d1, input alu_word_t d2);
        @(posedge clk);
        #1;
        req.op    = op;
        req.data1 = d1;
        req.data2 = d2;
        seq       = seq + 1;
    endtask

    task automatic corner_pairs();
        alu_word_t firsts[7];
        alu_word_t seconds[7];
        firsts  = '{8'h00, 8'hff, 8'h05, 8'h80, 8'hff, 8'haa, 8'h7f};
        seconds = '{8'h00, 8'h01, 8'hfb, 8'h80, 8'hff, 8'h55, 8'h01};
        // Every opcode sees the wrapping add pairs
        for (int op = 0; op < 8; op++) begin
            for (int p = 0; p < 7; p++) begin
                drive_request(alu_op_e'(op), firsts[p], seconds[p]);
            end
        end
    endtask

    task automatic multiply_corners();
        alu_word_t vals[3];
        vals = '{8'h00, 8'h01, 8'hff};
        for (int x = 0; x < 3; x++) begin
            for (int y = 0; y < 3; y++) begin
                drive_request(op_mult, vals[x], vals[y]);
            end
        end
    endtask

    task automatic sweep_amounts(input alu_op_e op, input alu_word_t data);
        for (int amt = 0; amt < 256; amt++) begin
            drive_request(op, data, amt[7:0]);
        end
    endtask

    initial begin
        reset = 1'b1;
        req   = '0;
        seq   = 0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        corner_pairs();

        for (i = 0; i < 200; i++) begin
            a = $random(seed);
            b = $random(seed);
            drive_request(alu_op_e'(i % 4), a, b);
        end

        multiply_corners();
        for (i = 0; i < 100; i++) begin
            a = $random(seed);
            b = $random(seed);
            drive_request(op_mult, a, b);
        end

        // Full signed amount range, fixed then random data
        sweep_amounts(op_sll, 8'hb5);
        sweep_amounts(op_sll, 8'h4c);
        sweep_amounts(op_sra, 8'hb5);
        sweep_amounts(op_sra, 8'h4c);
        sweep_amounts(op_rot, 8'hb5);
        sweep_amounts(op_rot, 8'h81);
        for (i = 0; i < 3; i++) begin
            a = $random(seed);
            sweep_amounts(op_sll, a);
            a = $random(seed);
            sweep_amounts(op_sra, a);
            a = $random(seed);
            sweep_amounts(op_rot, a);
        end

        // Back to back mixed stream
        for (i = 0; i < 500; i++) begin
            j = $random(seed);
            a = $random(seed);
            b = $random(seed);
            drive_request(alu_op_e'(j[2:0]), a, b);
        end

        cycles = 0;
        while (checked_seq != seq && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles = cycles + 1;
        end

        if (checked_seq == seq) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Timed out waiting for the last response to be checked");
            $display("TESTS FAILED");
            $fatal(1, "drain timeout");
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
+incdir+testbench
common/alu_pkg.sv
multiplier/array_multiplier.sv
shifter/barrel_shifter.sv
shifter/shift_unit.sv
rtl/alu.sv
testbench/alu_tb.sv
